//--- common/roverPkg.sv
package roverPkg;

    // Drive opcodes, codes 11 to 15 fall back to STOP
    typedef enum logic [3:0] {
        STOP       = 4'd0,
        LEFT       = 4'd1,
        RIGHT      = 4'd2,
        FWD_SLOW   = 4'd3,
        FWD_MED    = 4'd4,
        FWD_FAST   = 4'd5,
        REVERSE    = 4'd6,
        LREVERSE   = 4'd7,
        RREVERSE   = 4'd8,
        HARD_LEFT  = 4'd9,
        HARD_RIGHT = 4'd10
    } driveOpT;

    // Wheel speed codes, each maps to a fixed decimal text
    typedef enum logic [3:0] {
        ZERO = 4'd0,    // "0"
        P005 = 4'd1,    // "0.05"
        P012 = 4'd2,    // "0.12"
        P025 = 4'd3,    // "0.25"
        P05  = 4'd4,    // "0.5"
        N000 = 4'd5,    // "-0.00"
        N010 = 4'd6,    // "-0.10"
        N012 = 4'd7     // "-0.12"
    } speedT;

    // Byte lane towards the UART
    typedef struct packed {
        logic [7:0] data;   // ASCII character
        logic       last;   // Final newline of the frame
        logic       valid;  // Byte offered
    } byteStreamT;

    // Bit timing, small for fast simulation
    localparam int CLKS_PER_BIT     = 8;
    localparam int BIT_CNT_W        = 16;   // Bit-period counter width
    localparam int FRAME_GAP_CYCLES = 32;
    localparam int GAP_CNT_W        = 16;   // Gap counter width
    localparam int MAX_FRAME_LEN    = 28;

    // Fixed frame text around the two speeds
    localparam int PREFIX_LEN = 11;
    localparam int MID_LEN    = 5;
    localparam int TAIL_LEN   = 2;
    localparam int FIXED_LEN  = PREFIX_LEN + MID_LEN + TAIL_LEN;   // 18 bytes
    localparam logic [8*PREFIX_LEN-1:0] PREFIX_TXT = "{\"T\":1,\"L\":";
    localparam logic [8*MID_LEN-1:0]    MID_TXT    = ",\"R\":";
    localparam logic [8*TAIL_LEN-1:0]   TAIL_TXT   = {8'h7D, 8'h0A};   // Brace, newline

    // Speed text, first character in the top byte
    function automatic logic [39:0] speedText(speedT s);
        case (s)
            P005:    return {"0.05", 8'h00};
            P012:    return {"0.12", 8'h00};
            P025:    return {"0.25", 8'h00};
            P05:     return {"0.5", 16'h0000};
            N000:    return "-0.00";
            N010:    return "-0.10";
            N012:    return "-0.12";
            default: return {"0", 32'h0};     // ZERO
        endcase
    endfunction

    // Number of characters in the speed text
    function automatic logic [2:0] speedLen(speedT s);
        case (s)
            ZERO:             return 3'd1;
            P05:              return 3'd3;
            P005, P012, P025: return 3'd4;
            default:          return 3'd5;    // Negative speeds
        endcase
    endfunction

    // One character of the speed text
    function automatic logic [7:0] speedChar(speedT s, logic [2:0] idx);
        logic [39:0] txt;
        txt = speedText(s);
        return txt[39 - 8*idx -: 8];
    endfunction

endpackage

//--- uart/uartTx.sv
`timescale 1ns/1ps

module uartTx
    import roverPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  byteStreamT inByte,    // Byte offered by generator
    output logic       txReady,   // Idle, can accept
    output logic       txd        // Serial line, idles high
);

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } txStateT;

    txStateT              state;
    logic [BIT_CNT_W-1:0] clkCnt;     // Cycles within current bit
    logic [3:0]           bitCnt;     // 0 start, 1..8 data, 9 stop
    logic [8:0]           shiftReg;   // Data bits then stop bit
    logic                 accept;
    logic                 bitEnd;     // Last cycle of a bit

    assign txReady = (state == TX_IDLE);
    assign accept  = inByte.valid && txReady;
    assign bitEnd  = (clkCnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= TX_IDLE;
            clkCnt <= '0;
            bitCnt <= 4'd0;
            txd    <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (accept) begin
                        txd    <= 1'b0;            // Start bit
                        clkCnt <= '0;
                        bitCnt <= 4'd0;
                        state  <= TX_SEND;
                    end
                end
                default: begin
                    if (bitEnd) begin
                        clkCnt <= '0;
                        if (bitCnt == 4'd9) begin
                            state <= TX_IDLE;      // Stop bit done, line stays high
                        end else begin
                            txd    <= shiftReg[0]; // LSB first, then stop
                            bitCnt <= bitCnt + 4'd1;
                        end
                    end else begin
                        clkCnt <= clkCnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Payload shifter
    always_ff @(posedge clk) begin
        if (accept) begin
            shiftReg <= {1'b1, inByte.data};       // Stop bit behind data
        end else if (state == TX_SEND && bitEnd) begin
            shiftReg <= {1'b1, shiftReg[8:1]};
        end
    end

    // Line must rest high between bytes
    assert property (@(posedge clk) disable iff (rst)
        state == TX_IDLE |-> txd);

endmodule

//--- rtl/frameScheduler.sv
`timescale 1ns/1ps

module frameScheduler
    import roverPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    enable,     // Keep sending frames
    input  driveOpT driveOp,    // Live opcode
    input  logic    frameEnd,   // From generator
    output logic    start,      // One-cycle frame request
    output driveOpT curOp,      // Opcode for current frame
    output logic    busy,
    output logic    frameDone
);

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        GAP
    } schedStateT;

    schedStateT           state;
    logic [GAP_CNT_W-1:0] gapCnt;     // Cycles since frameDone
    logic                 gapOver;    // Last gap cycle

    assign gapOver = (gapCnt == GAP_CNT_W'(FRAME_GAP_CYCLES - 1));
    assign busy    = (state == SEND);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            gapCnt    <= '0;
            start     <= 1'b0;
            frameDone <= 1'b0;
            curOp     <= STOP;
        end else begin
            start     <= 1'b0;                     // Pulses by default
            frameDone <= 1'b0;
            case (state)
                IDLE: begin
                    if (enable) begin
                        start <= 1'b1;
                        curOp <= driveOp;          // Opcode frozen for frame
                        state <= SEND;
                    end
                end
                SEND: begin
                    if (frameEnd) begin
                        frameDone <= 1'b1;
                        gapCnt    <= '0;
                        state     <= GAP;
                    end
                end
                default: begin                     // GAP
                    gapCnt <= gapCnt + 1'b1;
                    if (gapOver) begin
                        if (enable) begin
                            start <= 1'b1;
                            curOp <= driveOp;
                            state <= SEND;
                        end else begin
                            state <= IDLE;         // Enable dropped, stop here
                        end
                    end
                end
            endcase
        end
    end

    // No second start once a frame is running
    assert property (@(posedge clk) disable iff (rst)
        start |-> $past(state) != SEND);

    assert property (@(posedge clk) disable iff (rst)
        frameDone |=> !frameDone);

endmodule

//--- rtl/jsonFrameGen.sv
`timescale 1ns/1ps

module jsonFrameGen
    import roverPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,      // Frame request from scheduler
    input  driveOpT    curOp,      // Latched opcode
    input  logic       txReady,    // UART can take a byte
    output byteStreamT outByte,
    output logic       frameEnd,   // Last byte accepted
    output logic [7:0] frameLen
);

    typedef enum logic [2:0] {
        SEG_PREFIX,
        SEG_LEFT,
        SEG_MID,
        SEG_RIGHT,
        SEG_TAIL
    } segT;

    segT        seg;          // Current text segment
    logic [3:0] idx;          // Character within segment
    logic       validQ;       // Frame running
    speedT      opLeft;       // Decoded from curOp
    speedT      opRight;
    speedT      leftSpd;      // Held for the frame
    speedT      rightSpd;
    logic [3:0] lastIdx;      // Final index of current segment
    logic       isLast;       // Newline byte on the lane
    logic       accept;       // Byte handed over
    logic [7:0] charSel;

    // Opcode to wheel speeds
    always_comb begin
        case (curOp)
            LEFT:       begin opLeft = N000; opRight = P012; end
            RIGHT:      begin opLeft = P012; opRight = N000; end
            FWD_SLOW:   begin opLeft = P005; opRight = P005; end
            FWD_MED:    begin opLeft = P025; opRight = P025; end
            FWD_FAST:   begin opLeft = P05;  opRight = P05;  end
            REVERSE:    begin opLeft = N010; opRight = N010; end
            LREVERSE:   begin opLeft = N000; opRight = N010; end
            RREVERSE:   begin opLeft = N010; opRight = N000; end
            HARD_LEFT:  begin opLeft = N012; opRight = P012; end
            HARD_RIGHT: begin opLeft = P012; opRight = N012; end
            default:    begin opLeft = ZERO; opRight = ZERO; end   // STOP and undefined
        endcase
    end

    // Segment length and character pick
    always_comb begin
        case (seg)
            SEG_PREFIX: begin
                lastIdx = 4'(PREFIX_LEN - 1);
                charSel = PREFIX_TXT[8*PREFIX_LEN - 1 - 8*idx -: 8];
            end
            SEG_LEFT: begin
                lastIdx = {1'b0, speedLen(leftSpd)} - 4'd1;
                charSel = speedChar(leftSpd, idx[2:0]);
            end
            SEG_MID: begin
                lastIdx = 4'(MID_LEN - 1);
                charSel = MID_TXT[8*MID_LEN - 1 - 8*idx -: 8];
            end
            SEG_RIGHT: begin
                lastIdx = {1'b0, speedLen(rightSpd)} - 4'd1;
                charSel = speedChar(rightSpd, idx[2:0]);
            end
            default: begin
                lastIdx = 4'(TAIL_LEN - 1);
                charSel = TAIL_TXT[8*TAIL_LEN - 1 - 8*idx[0] -: 8];
            end
        endcase
    end

    assign isLast   = (seg == SEG_TAIL) && (idx == lastIdx);
    assign accept   = validQ && txReady;
    assign frameEnd = accept && isLast;
    assign outByte  = '{data: charSel, last: isLast, valid: validQ};

    // Walk segments, advance only on acceptance
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validQ   <= 1'b0;
            seg      <= SEG_PREFIX;
            idx      <= 4'd0;
            frameLen <= 8'd0;
        end else if (!validQ) begin
            if (start) begin                       // Start ignored mid-frame
                validQ   <= 1'b1;
                seg      <= SEG_PREFIX;
                idx      <= 4'd0;
                frameLen <= 8'(FIXED_LEN) + {5'd0, speedLen(opLeft)}
                            + {5'd0, speedLen(opRight)};
            end
        end else if (accept) begin
            if (isLast) begin
                validQ <= 1'b0;                    // Frame complete
            end else if (idx == lastIdx) begin
                idx <= 4'd0;
                case (seg)
                    SEG_PREFIX: seg <= SEG_LEFT;
                    SEG_LEFT:   seg <= SEG_MID;
                    SEG_MID:    seg <= SEG_RIGHT;
                    default:    seg <= SEG_TAIL;
                endcase
            end else begin
                idx <= idx + 4'd1;
            end
        end
    end

    // Speeds captured with the frame
    always_ff @(posedge clk) begin
        if (!validQ && start) begin
            leftSpd  <= opLeft;
            rightSpd <= opRight;
        end
    end

    // Stalled byte must not change under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        outByte.valid && !txReady |=> outByte.valid && $stable(outByte.data)
            && $stable(outByte.last));

endmodule

//--- rtl/roverLinkTop.sv
`timescale 1ns/1ps

module roverLinkTop
    import roverPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,      // Repeat frames while high
    input  driveOpT    driveOp,     // Requested motion
    output logic       txd,         // UART line to rover
    output logic       busy,        // Frame in progress
    output logic       frameDone,   // One pulse per frame
    output logic [7:0] frameLen     // Bytes in current frame
);

    logic       start;      // Scheduler kicks generator
    driveOpT    curOp;      // Opcode latched for frame
    byteStreamT txByte;     // Generator to UART
    logic       txReady;
    logic       frameEnd;   // Last byte taken

    frameScheduler u_frameScheduler (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .driveOp   (driveOp),
        .frameEnd  (frameEnd),
        .start     (start),
        .curOp     (curOp),
        .busy      (busy),
        .frameDone (frameDone)
    );

    jsonFrameGen u_jsonFrameGen (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .curOp    (curOp),
        .txReady  (txReady),
        .outByte  (txByte),
        .frameEnd (frameEnd),
        .frameLen (frameLen)
    );

    uartTx u_uartTx (
        .clk     (clk),
        .rst     (rst),
        .inByte  (txByte),
        .txReady (txReady),
        .txd     (txd)
    );

endmodule

//--- testbench/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 20;  // 40 ns period
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;                             // Held from time zero
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;                            // Released on a rising edge
    end

endmodule

//--- testbench/uartRxModel.sv
`timescale 1ns/1ps

module uartRxModel
    import roverPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       txd,        // Line from DUT
    output logic [7:0] rxData,     // Last byte received
    output logic       rxStrobe,   // One pulse per byte
    output logic       rxStop      // Stop bit level of that byte
);

    logic [7:0] shiftIn;           // Data bits as they arrive

    initial begin
        rxData   = 8'h00;
        rxStrobe = 1'b0;
        rxStop   = 1'b1;
        shiftIn  = 8'h00;
    end

    // Sampling on falling edges keeps clear of DUT updates
    always begin
        @(negedge clk);
        rxStrobe <= 1'b0;
        if (!rst && txd === 1'b0) begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);  // Middle of start bit
            if (txd === 1'b0) begin                   // Ignore short glitches
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    shiftIn[i] = txd;                 // LSB first
                end
                repeat (CLKS_PER_BIT) @(negedge clk); // Middle of stop bit
                rxData   <= shiftIn;
                rxStop   <= txd;
                rxStrobe <= 1'b1;
            end
        end
    end

endmodule

//--- testbench/roverLinkTb.sv
`timescale 1ns/1ps

module roverLinkTb
    import roverPkg::*;
;

    localparam int NUM_ROWS       = 13;
    localparam int RESET_CYCLES   = 8;
    localparam int LATCH_A        = 5;     // FWD_FAST row
    localparam int LATCH_B        = 6;     // REVERSE row
    localparam int TIMEOUT_CYCLES =
        NUM_ROWS * (MAX_FRAME_LEN * 10 * CLKS_PER_BIT + FRAME_GAP_CYCLES) * 2 + RESET_CYCLES;
    localparam logic [31:0] RAND_SEED = 32'hd5c2fde2;

    logic       clk;
    logic       rst;
    logic       enable;
    driveOpT    driveOp;
    logic       txd;
    logic       busy;
    logic       frameDone;
    logic [7:0] frameLen;
    logic [7:0] rxData;
    logic       rxStrobe;
    logic       rxStop;

    logic [7:0] rxQ[$];        // Bytes seen on the line
    int         doneCnt;       // frameDone pulses so far
    int         cycleCnt;
    logic [7:0] lenAtDone;     // frameLen at the last frameDone
    driveOpT    opAtDone;      // Latched opcode at the last frameDone
    logic       busyS;
    logic       txdS;

    // Opcode, expected text, expected length
    logic [3:0] rowOp [NUM_ROWS] = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6,
                                     4'd7, 4'd8, 4'd9, 4'd10, 4'd11, 4'd15};
    string rowTxt [NUM_ROWS] = '{
        "{\"T\":1,\"L\":0,\"R\":0}\n",
        "{\"T\":1,\"L\":-0.00,\"R\":0.12}\n",
        "{\"T\":1,\"L\":0.12,\"R\":-0.00}\n",
        "{\"T\":1,\"L\":0.05,\"R\":0.05}\n",
        "{\"T\":1,\"L\":0.25,\"R\":0.25}\n",
        "{\"T\":1,\"L\":0.5,\"R\":0.5}\n",
        "{\"T\":1,\"L\":-0.10,\"R\":-0.10}\n",
        "{\"T\":1,\"L\":-0.00,\"R\":-0.10}\n",
        "{\"T\":1,\"L\":-0.10,\"R\":-0.00}\n",
        "{\"T\":1,\"L\":-0.12,\"R\":0.12}\n",
        "{\"T\":1,\"L\":0.12,\"R\":-0.12}\n",
        "{\"T\":1,\"L\":0,\"R\":0}\n",           // Undefined code 11
        "{\"T\":1,\"L\":0,\"R\":0}\n"            // Undefined code 15
    };
    int rowLen [NUM_ROWS] = '{20, 27, 27, 26, 26, 24, 28, 28, 28, 27, 27, 20, 20};

    tbClock u_tbClock (.clk(clk), .rst(rst));

    roverLinkTop u_roverLinkTop (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .driveOp   (driveOp),
        .txd       (txd),
        .busy      (busy),
        .frameDone (frameDone),
        .frameLen  (frameLen)
    );

    uartRxModel u_uartRxModel (
        .clk      (clk),
        .rst      (rst),
        .txd      (txd),
        .rxData   (rxData),
        .rxStrobe (rxStrobe),
        .rxStop   (rxStop)
    );

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic checkByte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp)
            abortRun($sformatf("Mismatch at %0t: %s got 8'h%02h expected 8'h%02h",
                               $time, what, got, exp));
    endtask

    task automatic checkLen(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp)
            abortRun($sformatf("Mismatch at %0t: %s frameLen %0d expected %0d",
                               $time, what, got, exp));
    endtask

    task automatic checkOp(input driveOpT got, input driveOpT exp);
        if (got !== exp)
            abortRun($sformatf("Mismatch at %0t: latched opcode %0d expected %0d",
                               $time, got, exp));
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp)
            abortRun($sformatf("Mismatch at %0t: %s is %b expected %b", $time, what, got, exp));
    endtask

    task automatic checkCount(input int got, input int exp, input string what);
        if (got != exp)
            abortRun($sformatf("Mismatch at %0t: %s %0d expected %0d", $time, what, got, exp));
    endtask

    // Outputs quiet while and right after reset
    task automatic checkIdle(input string when);
        checkBit(txd, 1'b1, {"txd ", when});
        checkBit(busy, 1'b0, {"busy ", when});
        checkBit(frameDone, 1'b0, {"frameDone ", when});
        checkLen(frameLen, 8'd0, when);
    endtask

    task automatic waitFrameDone(input int frameNo);
        while (doneCnt < frameNo) @(posedge clk);
    endtask

    // Pull one frame off the line and compare it with the row text
    task automatic collectFrame(input int r, input int frameNo);
        logic [7:0] got;
        while (rxQ.size() < rowLen[r]) @(posedge clk);
        checkCount(doneCnt, frameNo, "frameDone pulses by last stop bit");
        for (int i = 0; i < rowLen[r]; i++) begin
            got = rxQ.pop_front();
            checkByte(got, rowTxt[r][i], $sformatf("row %0d byte %0d", r, i));
        end
    endtask

    // Line and status snapshots on falling edges
    always @(negedge clk) begin
        busyS <= busy;
        txdS  <= txd;
        if (rxStrobe) begin
            if (rxStop !== 1'b1)
                abortRun("Framing error, the stop bit of a received byte was low");
            rxQ.push_back(rxData);
        end
        if (!rst && frameDone) begin
            doneCnt   <= doneCnt + 1;
            lenAtDone <= frameLen;
            opAtDone  <= u_roverLinkTop.curOp;
        end
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= TIMEOUT_CYCLES)
            abortRun($sformatf("Timeout, the run did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
    end

    initial begin
        int latchDelay;
        enable  = 1'b0;
        driveOp = STOP;
        void'($urandom(RAND_SEED));
        repeat (3) begin
            @(negedge clk);
            checkIdle("during reset");
        end
        while (rst) @(negedge clk);
        @(negedge clk);
        checkIdle("after reset");

        @(posedge clk);
        driveOp <= driveOpT'(rowOp[0]);
        enable  <= 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            waitFrameDone(r + 1);
            checkLen(lenAtDone, 8'(rowLen[r]), $sformatf("row %0d", r));
            checkOp(opAtDone, driveOpT'(rowOp[r]));
            @(posedge clk);                               // Next opcode inside the gap
            driveOp <= driveOpT'(rowOp[(r < NUM_ROWS - 1) ? r + 1 : LATCH_A]);
            collectFrame(r, r + 1);
        end

        // Opcode change in the middle of a running frame
        latchDelay = $urandom_range(1500, 1);
        repeat (latchDelay) @(posedge clk);
        if (busyS !== 1'b1)
            abortRun("The opcode change did not land inside a running frame");
        driveOp <= driveOpT'(rowOp[LATCH_B]);
        waitFrameDone(NUM_ROWS + 1);
        checkLen(lenAtDone, 8'(rowLen[LATCH_A]), "frame during opcode change");
        checkOp(opAtDone, driveOpT'(rowOp[LATCH_A]));
        collectFrame(LATCH_A, NUM_ROWS + 1);

        // Drop enable while the next frame runs
        @(posedge clk);
        checkBit(busyS, 1'b1, "busy when enable drops");
        enable <= 1'b0;
        waitFrameDone(NUM_ROWS + 2);
        checkLen(lenAtDone, 8'(rowLen[LATCH_B]), "frame after opcode change");
        checkOp(opAtDone, driveOpT'(rowOp[LATCH_B]));
        collectFrame(LATCH_B, NUM_ROWS + 2);
        repeat (2 * FRAME_GAP_CYCLES + CLKS_PER_BIT) begin
            @(posedge clk);
            checkBit(busyS, 1'b0, "busy after enable low");
            checkBit(txdS, 1'b1, "txd after enable low");
        end
        checkCount(doneCnt, NUM_ROWS + 2, "frameDone pulses in total");
        checkCount(rxQ.size(), 0, "bytes left over");
        $display("All checks passed");
        $finish;
    end

endmodule

//--- tb.f
common/roverPkg.sv
uart/uartTx.sv
rtl/frameScheduler.sv
rtl/jsonFrameGen.sv
rtl/roverLinkTop.sv
testbench/tbClock.sv
testbench/uartRxModel.sv
testbench/roverLinkTb.sv

//--- Makefile
TOP = roverLinkTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --assert -f tb.f --top-module $(TOP) \
		-Mdir obj_dir -o simv

run: compile
	-./obj_dir/simv > sim.log 2>&1
	@cat sim.log
	@if grep -q "Checks failed" sim.log; then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "All checks passed" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
